// File: build.f
verilog/mipsPkg.sv
verilog/hazardIf.sv
verilog/fetchStage.sv
verilog/decodeStage.sv
verilog/hazardUnit.sv
verilog/executeStage.sv
verilog/memWbStage.sv
verilog/mipsCore.sv
dv/isaModel.sv
dv/mipsTb.sv

// File: dv/isaModel.sv
/* Instruction encoder and sequential ISA model for the core testbench
   Programs must branch forward only; execution ends past the last word */
package isaModel;
  import mipsPkg::*;

  // Expected trace, in program order
  regAddr_t expRegAddr [$];
  word_t    expRegData [$];
  word_t    expMemAddr [$];
  word_t    expMemData [$];

  function automatic word_t encR(funct_e f, regAddr_t rd, regAddr_t rs, regAddr_t rt);
    return {R_TYPE, rs, rt, rd, 5'd0, f};
  endfunction

  function automatic word_t encI(opcode_e op, regAddr_t rs, regAddr_t rt, logic [15:0] imm);
    return {op, rs, rt, imm};
  endfunction

  function automatic word_t encJ(logic [25:0] tgt);
    return {J, tgt};                                  // Word index of the target
  endfunction

  task automatic runModel(input word_t prog [], input int dmemDepth);
    word_t    regs [32];
    word_t    mem [];
    word_t    instr, pc, next, simm, addr, val;
    regAddr_t rs, rt, dest;
    logic     wr;
    mem = new[dmemDepth];
    foreach (regs[i]) regs[i] = '0;
    foreach (mem[i]) mem[i] = '0;
    expRegAddr.delete();
    expRegData.delete();
    expMemAddr.delete();
    expMemData.delete();
    pc = '0;
    while (pc[31:2] < prog.size()) begin
      instr = prog[pc[31:2]];
      rs    = instr[25:21];
      rt    = instr[20:16];
      simm  = {{16{instr[15]}}, instr[15:0]};
      next  = pc + 32'd4;
      wr    = 1'b0;
      dest  = rt;
      val   = '0;
      case (opcode_e'(instr[31:26]))
        R_TYPE: begin
          dest = instr[15:11];
          wr   = 1'b1;
          case (funct_e'(instr[5:0]))
            F_ADD:   val = regs[rs] + regs[rt];
            F_SUB:   val = regs[rs] - regs[rt];
            F_AND:   val = regs[rs] & regs[rt];
            F_OR:    val = regs[rs] | regs[rt];
            F_SLT:   val = ($signed(regs[rs]) < $signed(regs[rt])) ? 32'd1 : 32'd0;
            default: wr = 1'b0;               // Padding word, nothing happens
          endcase
        end
        ADDI: begin
          wr  = 1'b1;
          val = regs[rs] + simm;
        end
        LW: begin
          addr = regs[rs] + simm;
          wr   = 1'b1;
          val  = mem[addr[31:2] % dmemDepth];
        end
        SW: begin
          addr = regs[rs] + simm;
          mem[addr[31:2] % dmemDepth] = regs[rt];
          expMemAddr.push_back(addr);
          expMemData.push_back(regs[rt]);
        end
        BEQ: if (regs[rs] == regs[rt]) next = pc + 32'd4 + {simm[29:0], 2'b00};
        J:   next = {next[31:28], instr[25:0], 2'b00};
        default: ;
      endcase
      if (wr && dest != '0) begin               // $0 stays zero and is never traced
        regs[dest] = val;
        expRegAddr.push_back(dest);
        expRegData.push_back(val);
      end
      pc = next;
    end
  endtask

endpackage

// File: dv/mipsTb.sv
/* Random program testbench for the pipelined core, seed fixed
   Traces are checked in order against the sequential model */
`timescale 1ns/1ps
module mipsTb;
  import mipsPkg::*;
  import isaModel::*;

  localparam int IMEM_DEPTH     = 256;
  localparam int DMEM_DEPTH     = 64;
  localparam int PROG_LEN       = 150;
  localparam int TIMEOUT_CYCLES = 3 * PROG_LEN + 200;

  logic     clk, rst, instLoad, memWrite, regWrite;
  word_t    instAddr, instData, memAddr, memWriteData, regWriteData;
  regAddr_t regAddr;
  word_t    prog [];
  int       cycles;

  mipsCore #(.IMEM_DEPTH(IMEM_DEPTH), .DMEM_DEPTH(DMEM_DEPTH)) UUT (
    .clk(clk), .rst(rst),
    .instLoad_i(instLoad), .instAddr_i(instAddr), .instData_i(instData),
    .memAddr_o(memAddr), .memWriteData_o(memWriteData), .memWrite_o(memWrite),
    .regAddr_o(regAddr), .regWriteData_o(regWriteData), .regWrite_o(regWrite)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  task automatic stopOnFailure();
    $display(">>> FAIL");
    $fatal(1, "Run stopped");
  endtask

  task automatic compareWord(string sigName, word_t got, word_t exp);
    if (got !== exp) begin
      $display("ERR %s got 0x%08h expected 0x%08h", sigName, got, exp);
      stopOnFailure();
    end
  endtask

  task automatic compareReg(string sigName, regAddr_t got, regAddr_t exp);
    if (got !== exp) begin
      $display("ERR %s got 0x%02h expected 0x%02h", sigName, got, exp);
      stopOnFailure();
    end
  endtask

  function automatic regAddr_t pickReg();
    return regAddr_t'($urandom % 8);            // Few registers, many hazards
  endfunction

  function automatic funct_e pickFunct();
    funct_e f;
    case ($urandom % 5)
      0:       f = F_ADD;
      1:       f = F_SUB;
      2:       f = F_AND;
      3:       f = F_OR;
      default: f = F_SLT;
    endcase
    return f;
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // Program builder
  ////////////////////////////////////////////////////////////////////////////
  task automatic buildProgram();
    int          idx;
    int          kind;
    regAddr_t    rd, rs, rt;
    logic [15:0] off;
    prog = new[IMEM_DEPTH];
    foreach (prog[i]) prog[i] = NOP_WORD;
    idx = 0;
    while (idx < PROG_LEN) begin
      kind = $urandom % 10;
      rd   = pickReg();
      rs   = pickReg();
      rt   = pickReg();
      off  = 16'(($urandom % DMEM_DEPTH) * 4);
      if (kind >= 8 && idx > PROG_LEN - 3) kind = 0;
      case (kind)
        0, 1, 2: prog[idx] = encR(pickFunct(), rd, rs, rt);
        3:       prog[idx] = encI(ADDI, rs, rt, 16'($urandom % 64) - 16'd32);
        4:       prog[idx] = encI(LW, '0, rt, off);
        5:       prog[idx] = encI(SW, '0, rt, off);
        6:       prog[idx] = encI(BEQ, rs, rt, 16'(1 + $urandom % 4));  // Forward only
        7:       prog[idx] = encJ(26'(idx + 2 + $urandom % 4));
        default: begin
          rd = regAddr_t'(1 + $urandom % 7);
          // Producer, ALU result or load
          prog[idx] = (kind == 8) ? encI(ADDI, rs, rd, 16'($urandom % 8))
                                  : encI(LW, '0, rd, off);
          idx++;
          if ($urandom % 3 == 0) begin            // Gap of one, writeback forwarding
            prog[idx] = encR(pickFunct(), pickReg(), rs, rt);
            idx++;
          end
          if ($urandom % 2) prog[idx] = encR(pickFunct(), rt, rd, rs);
          else              prog[idx] = encI(BEQ, rd, rs, 16'(1 + $urandom % 3));
        end
      endcase
      idx++;
    end
  endtask

  // Outputs settle after the rising edge, so compare on the falling one
  always @(negedge clk) begin
    if (!rst && regWrite) begin
      if (expRegAddr.size() == 0) begin
        $display("Register write to r%0d seen with none expected", regAddr);
        stopOnFailure();
      end else begin
        compareReg("regAddr_o", regAddr, expRegAddr.pop_front());
        compareWord("regWriteData_o", regWriteData, expRegData.pop_front());
      end
    end
    if (!rst && memWrite) begin
      if (expMemAddr.size() == 0) begin
        $display("Memory write to 0x%08h seen with none expected", memAddr);
        stopOnFailure();
      end else begin
        compareWord("memAddr_o", memAddr, expMemAddr.pop_front());
        compareWord("memWriteData_o", memWriteData, expMemData.pop_front());
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////////////////////////////////////////
  initial begin
    rst      = 1'b1;
    instLoad = 1'b0;
    instAddr = '0;
    instData = '0;
    void'($urandom(40012));
    buildProgram();
    runModel(prog, DMEM_DEPTH);
    repeat (16) @(posedge clk);
    rst <= 1'b0;
    // Load starts as reset drops, so no empty word is fetched
    for (int i = 0; i < IMEM_DEPTH; i++) begin  // Whole memory, padding too
      instLoad <= 1'b1;
      instAddr <= word_t'(i);
      instData <= prog[i];
      @(posedge clk);
    end
    instLoad <= 1'b0;
    cycles = 0;
    while ((expRegAddr.size() != 0 || expMemAddr.size() != 0) && cycles < TIMEOUT_CYCLES) begin
      @(posedge clk);
      cycles++;
    end
    repeat (8) @(posedge clk);                  // Room for stray writes to show
    if (expRegAddr.size() != 0 || expMemAddr.size() != 0) begin
      $display("Pipeline hung: %0d register and %0d memory writes missing after %0d cycles",
               expRegAddr.size(), expMemAddr.size(), cycles);
      stopOnFailure();
    end else begin
      $display(">>> PASS");
      $finish;
    end
  end

endmodule

// File: verilog/decodeStage.sv
/* Branches and jumps resolve here with no delay slot
   Register file reads return the value being written in the same cycle */
`timescale 1ns/1ps
module decodeStage (
  input  logic              clk,
  input  logic              rst,
  input  mipsPkg::word_t    instrD_i,
  input  mipsPkg::word_t    pcPlus4D_i,
  hazardIf.decode           hz,
  input  mipsPkg::word_t    aluOutM_i,
  input  mipsPkg::word_t    resultW_i,
  output logic              redirect_o,
  output mipsPkg::word_t    target_o,
  output mipsPkg::exCtrl_t  ctrlE_o,
  output mipsPkg::word_t    rd1E_o,
  output mipsPkg::word_t    rd2E_o,
  output mipsPkg::word_t    immE_o,
  output mipsPkg::regAddr_t destE_o
);
  import mipsPkg::*;

  opcode_e  opcode;
  funct_e   funct;
  exCtrl_t  ctrlD;
  logic     regDst, branch, jump;
  regAddr_t rs, rt, rd, destD;
  word_t    regFile [NUM_REGS];
  word_t    rd1, rd2, cmpA, cmpB, signImm;

  assign opcode = opcode_e'(instrD_i[31:26]);
  assign funct  = funct_e'(instrD_i[5:0]);
  assign rs     = instrD_i[25:21];
  assign rt     = instrD_i[20:16];
  assign rd     = instrD_i[15:11];

  ////////////////////////////////////////////////////////////////////////////
  // Control decoder
  ////////////////////////////////////////////////////////////////////////////
  always_comb begin
    ctrlD       = '0;
    ctrlD.aluOp = ALU_ADD;
    regDst      = 1'b0;
    branch      = 1'b0;
    jump        = 1'b0;
    case (opcode)
      R_TYPE: begin
        regDst         = 1'b1;
        ctrlD.regWrite = 1'b1;
        case (funct)
          F_ADD:   ctrlD.aluOp = ALU_ADD;
          F_SUB:   ctrlD.aluOp = ALU_SUB;
          F_AND:   ctrlD.aluOp = ALU_AND;
          F_OR:    ctrlD.aluOp = ALU_OR;
          F_SLT:   ctrlD.aluOp = ALU_SLT;
          default: ctrlD.regWrite = 1'b0;  // All-zero word lands here
        endcase
      end
      LW: begin
        ctrlD.regWrite = 1'b1;
        ctrlD.memToReg = 1'b1;
        ctrlD.aluSrc   = 1'b1;
      end
      SW: begin
        ctrlD.memWrite = 1'b1;
        ctrlD.aluSrc   = 1'b1;
      end
      ADDI: begin
        ctrlD.regWrite = 1'b1;
        ctrlD.aluSrc   = 1'b1;
      end
      BEQ:     branch = 1'b1;
      J:       jump   = 1'b1;
      default: ;
    endcase
  end

  assign destD = regDst ? rd : rt;

  // Register file, architectural state starts at zero
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      for (int i = 0; i < NUM_REGS; i++) begin
        regFile[i] <= '0;
      end
    end else if (hz.regWriteW) begin
      regFile[hz.destW] <= resultW_i;
    end
  end

  assign rd1 = (hz.regWriteW && hz.destW == rs) ? resultW_i : regFile[rs];
  assign rd2 = (hz.regWriteW && hz.destW == rt) ? resultW_i : regFile[rt];

  // Branch compare on forwarded operands
  assign cmpA       = hz.fwdAD ? aluOutM_i : rd1;
  assign cmpB       = hz.fwdBD ? aluOutM_i : rd2;
  assign signImm    = {{16{instrD_i[15]}}, instrD_i[15:0]};
  assign redirect_o = !hz.stallD && (jump || (branch && cmpA == cmpB));
  assign target_o   = jump ? {pcPlus4D_i[31:28], instrD_i[25:0], 2'b00}
                           : pcPlus4D_i + {signImm[29:0], 2'b00};

  assign hz.rsD       = rs;
  assign hz.rtD       = rt;
  assign hz.branchD   = branch;
  assign hz.redirectD = redirect_o;

  // Decode/execute register
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      ctrlE_o <= '0;
      destE_o <= '0;
    end else if (hz.flushE) begin
      ctrlE_o <= '0;                          // Bubble
      destE_o <= '0;
    end else begin
      ctrlE_o          <= ctrlD;
      ctrlE_o.regWrite <= ctrlD.regWrite && (destD != '0);  // Writes to $0 dropped here
      destE_o          <= destD;
    end
  end

  always_ff @(posedge clk) begin
    rd1E_o <= rd1;
    rd2E_o <= rd2;
    immE_o <= signImm;
  end

  knownOpcode: assert property (@(posedge clk) disable iff (rst)
    instrD_i[31:26] inside {R_TYPE, LW, SW, BEQ, ADDI, J});

endmodule

// File: verilog/executeStage.sv
/* Single-cycle ALU; slt compares as signed
   Execute never stalls, so its register loads every cycle */
`timescale 1ns/1ps
module executeStage (
  input  logic              clk,
  input  logic              rst,
  input  mipsPkg::exCtrl_t  ctrlE_i,
  input  mipsPkg::word_t    rd1E_i,
  input  mipsPkg::word_t    rd2E_i,
  input  mipsPkg::word_t    immE_i,
  input  mipsPkg::regAddr_t destE_i,
  hazardIf.execute          hz,
  input  mipsPkg::word_t    aluOutM_i,
  input  mipsPkg::word_t    resultW_i,
  output mipsPkg::word_t    aluOutM_o,
  output mipsPkg::word_t    writeDataM_o,
  output mipsPkg::regAddr_t destM_o,
  output logic              memToRegM_o,
  output logic              memWriteM_o,
  output logic              regWriteM_o
);
  import mipsPkg::*;

  regAddr_t rsE, rtE;
  word_t    srcA, writeData, srcB, aluOut;

  function automatic word_t fwdMux(input fwdSel_e sel, input word_t regVal,
                                   input word_t memVal, input word_t wbVal);
    word_t val;
    case (sel)
      FWD_MEM: val = memVal;
      FWD_WB:  val = wbVal;
      default: val = regVal;
    endcase
    return val;
  endfunction

  // Source numbers follow the instruction for forwarding checks
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      rsE <= '0;
      rtE <= '0;
    end else begin
      rsE <= hz.rsD;
      rtE <= hz.rtD;
    end
  end

  assign srcA      = fwdMux(hz.fwdAE, rd1E_i, aluOutM_i, resultW_i);
  assign writeData = fwdMux(hz.fwdBE, rd2E_i, aluOutM_i, resultW_i);
  assign srcB      = ctrlE_i.aluSrc ? immE_i : writeData;

  always_comb begin
    case (ctrlE_i.aluOp)
      ALU_AND: aluOut = srcA & srcB;
      ALU_OR:  aluOut = srcA | srcB;
      ALU_SUB: aluOut = srcA - srcB;
      ALU_SLT: aluOut = {31'd0, $signed(srcA) < $signed(srcB)};
      default: aluOut = srcA + srcB;
    endcase
  end

  assign hz.rsE       = rsE;
  assign hz.rtE       = rtE;
  assign hz.destE     = destE_i;
  assign hz.regWriteE = ctrlE_i.regWrite;
  assign hz.memToRegE = ctrlE_i.memToReg;

  // Execute/memory register
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      destM_o     <= '0;
      memToRegM_o <= 1'b0;
      memWriteM_o <= 1'b0;
      regWriteM_o <= 1'b0;
    end else begin
      destM_o     <= destE_i;
      memToRegM_o <= ctrlE_i.memToReg;
      memWriteM_o <= ctrlE_i.memWrite;
      regWriteM_o <= ctrlE_i.regWrite;
    end
  end

  always_ff @(posedge clk) begin
    aluOutM_o    <= aluOut;
    writeDataM_o <= writeData;
  end

endmodule

// File: verilog/fetchStage.sv
/* Instruction memory is written only through the load port, with the PC held at 0
   Fetch and load addresses are word indices taken modulo IMEM_DEPTH */
`timescale 1ns/1ps
module fetchStage #(
  parameter int IMEM_DEPTH = 256
) (
  input  logic           clk,
  input  logic           rst,
  input  logic           instLoad_i,
  input  mipsPkg::word_t instAddr_i,
  input  mipsPkg::word_t instData_i,
  hazardIf.fetch         hz,
  input  logic           redirect_i,
  input  mipsPkg::word_t target_i,
  output mipsPkg::word_t instrD_o,
  output mipsPkg::word_t pcPlus4D_o
);
  import mipsPkg::*;

  word_t pcF;
  word_t pcPlus4F;
  word_t instrF;
  word_t imem [IMEM_DEPTH];

  always_ff @(posedge clk) begin
    if (instLoad_i) begin
      imem[instAddr_i % IMEM_DEPTH] <= instData_i;
    end
  end

  assign pcPlus4F = pcF + 32'd4;
  assign instrF   = imem[pcF[31:2] % IMEM_DEPTH];  // Asynchronous read

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      pcF <= '0;
    end else if (instLoad_i) begin
      pcF <= '0;                                  // Start over at word 0
    end else if (!hz.stallF) begin
      pcF <= redirect_i ? target_i : pcPlus4F;
    end
  end

  // Fetch/decode register, cleared to a bubble on redirect or load
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      instrD_o <= NOP_WORD;
    end else if (instLoad_i || redirect_i) begin
      instrD_o <= NOP_WORD;
    end else if (!hz.stallF) begin
      instrD_o <= instrF;
    end
  end

  always_ff @(posedge clk) begin
    if (!hz.stallF) begin
      pcPlus4D_o <= pcPlus4F;
    end
  end

  // A stalled PC would drop the redirect target
  noRedirectOnStall: assert property (@(posedge clk) disable iff (rst)
    !(redirect_i && hz.stallF));

endmodule

// File: verilog/hazardIf.sv
/* Hazard inputs from the stages and stall, flush and forward controls back
   Register numbers of zero never carry a write here */
`timescale 1ns/1ps
interface hazardIf (input logic clk);
  import mipsPkg::*;

  regAddr_t rsD, rtD, rsE, rtE;
  regAddr_t destE, destM, destW;
  logic     branchD, redirectD;
  logic     regWriteE, memToRegE;
  logic     regWriteM, memToRegM;
  logic     regWriteW;
  logic     stallF, stallD, flushE;
  logic     fwdAD, fwdBD;
  fwdSel_e  fwdAE, fwdBE;

  modport hazard (input clk, rsD, rtD, branchD, redirectD, rsE, rtE, destE, regWriteE,
                  memToRegE, destM, regWriteM, memToRegM, destW, regWriteW,
                  output stallF, stallD, flushE, fwdAD, fwdBD, fwdAE, fwdBE);
  modport fetch (input stallF);
  modport decode (output rsD, rtD, branchD, redirectD,
                  input stallD, flushE, fwdAD, fwdBD, destW, regWriteW);
  modport execute (input rsD, rtD, fwdAE, fwdBE,
                   output rsE, rtE, destE, regWriteE, memToRegE);
  modport memWb (output destM, regWriteM, memToRegM, destW, regWriteW);
endinterface

// File: verilog/hazardUnit.sv
/* Forwarding selects and stall/flush controls, purely combinational
   Register zero never shows a write, so no zero checks are made */
`timescale 1ns/1ps
module hazardUnit (
  hazardIf.hazard hz
);
  import mipsPkg::*;

  logic srcHitE;
  logic srcHitM;
  logic loadUse;
  logic branchStall;
  logic stall;

  // Memory stage wins over writeback
  function automatic fwdSel_e pickFwd(
    input regAddr_t src,
    input regAddr_t destM,
    input logic     regWriteM,
    input regAddr_t destW,
    input logic     regWriteW
  );
    fwdSel_e sel;
    if (regWriteM && src == destM) begin
      sel = FWD_MEM;
    end else if (regWriteW && src == destW) begin
      sel = FWD_WB;
    end else begin
      sel = FWD_REG;
    end
    return sel;
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // Forwarding
  ////////////////////////////////////////////////////////////////////////////
  assign hz.fwdAE = pickFwd(hz.rsE, hz.destM, hz.regWriteM, hz.destW, hz.regWriteW);
  assign hz.fwdBE = pickFwd(hz.rtE, hz.destM, hz.regWriteM, hz.destW, hz.regWriteW);

  // Decode only sees the ALU result in memory
  assign hz.fwdAD = hz.regWriteM && hz.rsD == hz.destM;
  assign hz.fwdBD = hz.regWriteM && hz.rtD == hz.destM;

  ////////////////////////////////////////////////////////////////////////////
  // Stalls
  ////////////////////////////////////////////////////////////////////////////
  assign srcHitE     = hz.destE == hz.rsD || hz.destE == hz.rtD;
  assign srcHitM     = hz.destM == hz.rsD || hz.destM == hz.rtD;
  assign loadUse     = hz.memToRegE && srcHitE;
  assign branchStall = hz.branchD && ((hz.regWriteE && srcHitE) || (hz.memToRegM && srcHitM));
  assign stall       = loadUse || branchStall;

  assign hz.stallF = stall;
  assign hz.stallD = stall;
  assign hz.flushE = stall || hz.redirectD;  // Resolved branch carries nothing onward

  // A load-use stall leaves a bubble in execute
  bubbleAfterLoadUse: assert property (@(posedge hz.clk) loadUse |=> !hz.memToRegE);

endmodule

// File: verilog/memWbStage.sv
/* Data memory is word addressed, modulo DMEM_DEPTH, and cleared at reset
   Trace ports show stores from memory and register writes from writeback */
`timescale 1ns/1ps
module memWbStage #(
  parameter int DMEM_DEPTH = 64
) (
  input  logic              clk,
  input  logic              rst,
  input  mipsPkg::word_t    aluOutM_i,
  input  mipsPkg::word_t    writeDataM_i,
  input  mipsPkg::regAddr_t destM_i,
  input  logic              memToRegM_i,
  input  logic              memWriteM_i,
  input  logic              regWriteM_i,
  hazardIf.memWb            hz,
  output mipsPkg::word_t    aluOutM_o,
  output mipsPkg::word_t    resultW_o,
  output mipsPkg::word_t    memAddr_o,
  output mipsPkg::word_t    memWriteData_o,
  output logic              memWrite_o,
  output mipsPkg::regAddr_t regAddr_o,
  output mipsPkg::word_t    regWriteData_o,
  output logic              regWrite_o
);
  import mipsPkg::*;

  word_t    dmem [DMEM_DEPTH];
  word_t    readDataM, resultM, resultW;
  regAddr_t destW;
  logic     regWriteW;

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      for (int i = 0; i < DMEM_DEPTH; i++) begin
        dmem[i] <= '0;
      end
    end else if (memWriteM_i) begin
      dmem[aluOutM_i[31:2] % DMEM_DEPTH] <= writeDataM_i;
    end
  end

  assign readDataM = dmem[aluOutM_i[31:2] % DMEM_DEPTH];
  assign resultM   = memToRegM_i ? readDataM : aluOutM_i;

  // Memory/writeback register
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      destW     <= '0;
      regWriteW <= 1'b0;
    end else begin
      destW     <= destM_i;
      regWriteW <= regWriteM_i;
    end
  end

  always_ff @(posedge clk) begin
    resultW <= resultM;
  end

  assign aluOutM_o = aluOutM_i;          // Forwarding source for decode and execute
  assign resultW_o = resultW;

  assign hz.destM     = destM_i;
  assign hz.regWriteM = regWriteM_i;
  assign hz.memToRegM = memToRegM_i;
  assign hz.destW     = destW;
  assign hz.regWriteW = regWriteW;

  assign memAddr_o      = aluOutM_i;
  assign memWriteData_o = writeDataM_i;
  assign memWrite_o     = memWriteM_i;
  assign regAddr_o      = destW;
  assign regWriteData_o = resultW;
  assign regWrite_o     = regWriteW;

endmodule

// File: verilog/mipsCore.sv
/* Five-stage MIPS-I subset core; load the program with instLoad_i before running
   No external back-pressure, trace pulses come out in program order */
`timescale 1ns/1ps
module mipsCore #(
  parameter int IMEM_DEPTH = 256,
  parameter int DMEM_DEPTH = 64
) (
  input  logic              clk,
  input  logic              rst,
  input  logic              instLoad_i,
  input  mipsPkg::word_t    instAddr_i,
  input  mipsPkg::word_t    instData_i,
  output mipsPkg::word_t    memAddr_o,
  output mipsPkg::word_t    memWriteData_o,
  output logic              memWrite_o,
  output mipsPkg::regAddr_t regAddr_o,
  output mipsPkg::word_t    regWriteData_o,
  output logic              regWrite_o
);
  import mipsPkg::*;

  logic     redirect;
  word_t    target, instrD, pcPlus4D;
  exCtrl_t  ctrlE;
  word_t    rd1E, rd2E, immE;
  regAddr_t destE, destM;
  word_t    aluOutRegM, writeDataM, aluOutM, resultW;
  logic     memToRegM, memWriteM, regWriteM;

  hazardIf hz (.clk(clk));

  hazardUnit uHazard (.hz(hz.hazard));

  fetchStage #(.IMEM_DEPTH(IMEM_DEPTH)) uFetch (
    .clk(clk), .rst(rst),
    .instLoad_i(instLoad_i), .instAddr_i(instAddr_i), .instData_i(instData_i),
    .hz(hz.fetch),
    .redirect_i(redirect), .target_i(target),
    .instrD_o(instrD), .pcPlus4D_o(pcPlus4D)
  );

  decodeStage uDecode (
    .clk(clk), .rst(rst),
    .instrD_i(instrD), .pcPlus4D_i(pcPlus4D),
    .hz(hz.decode),
    .aluOutM_i(aluOutM), .resultW_i(resultW),
    .redirect_o(redirect), .target_o(target),
    .ctrlE_o(ctrlE), .rd1E_o(rd1E), .rd2E_o(rd2E), .immE_o(immE), .destE_o(destE)
  );

  executeStage uExecute (
    .clk(clk), .rst(rst),
    .ctrlE_i(ctrlE), .rd1E_i(rd1E), .rd2E_i(rd2E), .immE_i(immE), .destE_i(destE),
    .hz(hz.execute),
    .aluOutM_i(aluOutM), .resultW_i(resultW),
    .aluOutM_o(aluOutRegM), .writeDataM_o(writeDataM), .destM_o(destM),
    .memToRegM_o(memToRegM), .memWriteM_o(memWriteM), .regWriteM_o(regWriteM)
  );

  memWbStage #(.DMEM_DEPTH(DMEM_DEPTH)) uMemWb (
    .clk(clk), .rst(rst),
    .aluOutM_i(aluOutRegM), .writeDataM_i(writeDataM), .destM_i(destM),
    .memToRegM_i(memToRegM), .memWriteM_i(memWriteM), .regWriteM_i(regWriteM),
    .hz(hz.memWb),
    .aluOutM_o(aluOutM), .resultW_o(resultW),
    .memAddr_o(memAddr_o), .memWriteData_o(memWriteData_o), .memWrite_o(memWrite_o),
    .regAddr_o(regAddr_o), .regWriteData_o(regWriteData_o), .regWrite_o(regWrite_o)
  );

endmodule

// File: verilog/mipsPkg.sv
/* Shared types for the five-stage MIPS-I subset core
   Only add, sub, and, or, slt, addi, lw, sw, beq and j are decoded */
package mipsPkg;

  localparam int WORD_W   = 32;
  localparam int REG_W    = 5;
  localparam int NUM_REGS = 2 ** REG_W;

  typedef logic [WORD_W-1:0] word_t;
  typedef logic [REG_W-1:0]  regAddr_t;

  // Major opcodes, bits 31:26
  typedef enum logic [5:0] {
    R_TYPE = 6'b000000,
    J      = 6'b000010,
    BEQ    = 6'b000100,
    ADDI   = 6'b001000,
    LW     = 6'b100011,
    SW     = 6'b101011
  } opcode_e;

  // R-type function field, bits 5:0
  typedef enum logic [5:0] {
    F_ADD = 6'h20,
    F_SUB = 6'h22,
    F_AND = 6'h24,
    F_OR  = 6'h25,
    F_SLT = 6'h2a
  } funct_e;

  typedef enum logic [2:0] {
    ALU_AND = 3'b000,
    ALU_OR  = 3'b001,
    ALU_ADD = 3'b010,
    ALU_SUB = 3'b110,
    ALU_SLT = 3'b111
  } aluOp_e;

  // Operand source in execute
  typedef enum logic [1:0] {
    FWD_REG = 2'b00,
    FWD_WB  = 2'b01,
    FWD_MEM = 2'b10
  } fwdSel_e;

  // Control carried from decode into execute
  typedef struct packed {
    logic   regWrite;
    logic   memToReg;
    logic   memWrite;
    logic   aluSrc;
    aluOp_e aluOp;
  } exCtrl_t;

  localparam word_t NOP_WORD = '0;

endpackage
